// File: hw/ps2_display_pkg.sv
package ps2_display_pkg;

  // --------------------
  // Widths
  localparam int BYTE_W     = 8;       // One scan code
  localparam int NIBBLE_W   = 4;       // One hex digit
  localparam int SEG_W      = 7;       // Segments a to g
  localparam int DEC_BASE   = 10;
  localparam int DEC_DIGITS = 3;       // 255 needs three decimal digits
  localparam int DIV_STEPS  = BYTE_W;  // One quotient bit per step

  // --------------------
  // PS/2 frame
  localparam int RX_BIT_CNT_W = $clog2(BYTE_W);
  localparam logic [RX_BIT_CNT_W-1:0] RX_LAST_BIT = RX_BIT_CNT_W'(BYTE_W - 1);
  localparam int RX_STATE_W = 2;
  localparam logic [RX_STATE_W-1:0] RX_IDLE   = 2'd0;  // Waiting for start bit
  localparam logic [RX_STATE_W-1:0] RX_DATA   = 2'd1;  // Eight data bits, LSB first
  localparam logic [RX_STATE_W-1:0] RX_PARITY = 2'd2;
  localparam logic [RX_STATE_W-1:0] RX_STOP   = 2'd3;

  // --------------------
  // Divider and decimal conversion
  localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);
  localparam logic [DIV_CNT_W-1:0] DIV_COUNT_INIT = DIV_CNT_W'(DIV_STEPS);
  localparam logic [DIV_CNT_W-1:0] DIV_COUNT_LAST = DIV_CNT_W'(1);
  localparam logic [BYTE_W-1:0] DIVISOR = BYTE_W'(DEC_BASE);
  localparam int DIGIT_IDX_W = $clog2(DEC_DIGITS);
  localparam logic [DIGIT_IDX_W-1:0] LAST_DIGIT = DIGIT_IDX_W'(DEC_DIGITS - 1);
  localparam int CV_STATE_W = 1;
  localparam logic [CV_STATE_W-1:0] CV_IDLE   = 1'b0;
  localparam logic [CV_STATE_W-1:0] CV_DIVIDE = 1'b1;

  // Received byte, read as a number or as two hex digits
  typedef union packed {
    logic [BYTE_W-1:0] raw;     // Numeric view
    struct packed {
      logic [NIBBLE_W-1:0] hi;
      logic [NIBBLE_W-1:0] lo;
    } nibble;                   // Hex view
  } scan_byte_t;

  // Bit 0 is the top bar, bit 6 the middle bar
  function automatic logic [SEG_W-1:0] seg_encode(input logic [NIBBLE_W-1:0] value);
    logic [SEG_W-1:0] lit;  // Set bit lights a segment
    case (value)
      4'h0: lit = 7'b0111111;
      4'h1: lit = 7'b0000110;
      4'h2: lit = 7'b1011011;
      4'h3: lit = 7'b1001111;
      4'h4: lit = 7'b1100110;
      4'h5: lit = 7'b1101101;
      4'h6: lit = 7'b1111101;
      4'h7: lit = 7'b0000111;
      4'h8: lit = 7'b1111111;
      4'h9: lit = 7'b1101111;
      4'ha: lit = 7'b1110111;
      4'hb: lit = 7'b1111100;
      4'hc: lit = 7'b0111001;
      4'hd: lit = 7'b1011110;
      4'he: lit = 7'b1111001;
      default: lit = 7'b1110001;  // F
    endcase
    return ~lit;  // Active low at the pins
  endfunction

endpackage

// File: hw/ps2_receiver.sv
`timescale 1ns/1ps

module ps2_receiver (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        ps2_clk,      // Asynchronous, from the device
  input  logic                        ps2_data,     // Asynchronous, from the device
  output ps2_display_pkg::scan_byte_t scan_code,    // Last good byte
  output logic                        scan_valid,   // One cycle per good frame
  output logic                        frame_error   // One cycle per bad frame
);

  // --------------------
  // Line synchronizers
  logic clk_meta;
  logic clk_sync;
  logic clk_prev;   // Edge detector history
  logic data_meta;
  logic data_sync;
  logic clk_fall;   // Falling PS/2 clock seen this cycle

  // --------------------
  // Frame state
  logic [ps2_display_pkg::RX_STATE_W-1:0]   state;
  logic [ps2_display_pkg::RX_BIT_CNT_W-1:0] bit_cnt;   // Data bit index
  logic                                     parity;    // Running XOR of data and parity bits
  logic [ps2_display_pkg::BYTE_W-1:0]       shift_reg; // Byte being assembled

  // Lines idle high, so reset to one avoids a false edge
  always_ff @(posedge clk) begin
    if (reset) begin
      clk_meta  <= 1'b1;
      clk_sync  <= 1'b1;
      clk_prev  <= 1'b1;
      data_meta <= 1'b1;
      data_sync <= 1'b1;
    end else begin
      clk_meta  <= ps2_clk;
      clk_sync  <= clk_meta;
      clk_prev  <= clk_sync;
      data_meta <= ps2_data;
      data_sync <= data_meta;
    end
  end

  assign clk_fall = clk_prev & ~clk_sync;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ps2_display_pkg::RX_IDLE;
      bit_cnt     <= '0;
      parity      <= 1'b0;
      scan_code   <= '0;
      scan_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      scan_valid  <= 1'b0;   // Strobes last one cycle
      frame_error <= 1'b0;
      if (clk_fall) begin
        case (state)
          ps2_display_pkg::RX_IDLE: begin
            if (!data_sync) begin  // Start bit is low
              state   <= ps2_display_pkg::RX_DATA;
              bit_cnt <= '0;
              parity  <= 1'b0;
            end
          end
          ps2_display_pkg::RX_DATA: begin
            parity  <= parity ^ data_sync;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == ps2_display_pkg::RX_LAST_BIT) begin
              state <= ps2_display_pkg::RX_PARITY;
            end
          end
          ps2_display_pkg::RX_PARITY: begin
            parity <= parity ^ data_sync;  // Odd parity leaves a one
            state  <= ps2_display_pkg::RX_STOP;
          end
          default: begin                   // Stop bit
            state <= ps2_display_pkg::RX_IDLE;
            if (data_sync && parity) begin
              scan_code.raw <= shift_reg;
              scan_valid    <= 1'b1;
            end else begin
              frame_error <= 1'b1;         // Old byte stays on scan_code
            end
          end
        endcase
      end
    end
  end

  // Data shifter, LSB arrives first
  always_ff @(posedge clk) begin
    if (clk_fall && state == ps2_display_pkg::RX_DATA) begin
      shift_reg <= {data_sync, shift_reg[ps2_display_pkg::BYTE_W-1:1]};
    end
  end

endmodule

// File: hw/base_divider.sv
`timescale 1ns/1ps

// Non-restoring division of a byte by the decimal base
module base_divider (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               start,      // One-cycle pulse
  input  logic [ps2_display_pkg::BYTE_W-1:0] dividend,
  output logic [ps2_display_pkg::BYTE_W-1:0] quotient,
  output logic [ps2_display_pkg::BYTE_W-1:0] remainder,
  output logic                               done        // One-cycle pulse
);

  logic [2*ps2_display_pkg::BYTE_W-1:0] acc;          // Partial remainder over dividend bits
  logic [2*ps2_display_pkg::BYTE_W-1:0] acc_shifted;
  logic [ps2_display_pkg::BYTE_W-1:0]   rem_shifted;
  logic [ps2_display_pkg::BYTE_W-1:0]   rem_step;     // Signed partial remainder
  logic [ps2_display_pkg::BYTE_W-1:0]   rem_fixed;    // Corrected on the last step
  logic [ps2_display_pkg::DIV_CNT_W-1:0] count;       // Steps still to run
  logic                                 running;
  logic                                 last_step;

  assign remainder = acc[2*ps2_display_pkg::BYTE_W-1:ps2_display_pkg::BYTE_W];
  assign running   = (count != '0);
  assign last_step = (count == ps2_display_pkg::DIV_COUNT_LAST);

  // --------------------
  // One step
  always_comb begin
    acc_shifted = acc << 1;
    rem_shifted = acc_shifted[2*ps2_display_pkg::BYTE_W-1:ps2_display_pkg::BYTE_W];
    // Negative remainder adds the divisor back, positive subtracts
    rem_step = rem_shifted[ps2_display_pkg::BYTE_W-1] ? rem_shifted + ps2_display_pkg::DIVISOR
                                                      : rem_shifted - ps2_display_pkg::DIVISOR;
    rem_fixed = rem_step[ps2_display_pkg::BYTE_W-1] ? rem_step + ps2_display_pkg::DIVISOR
                                                    : rem_step;
  end

  // Step counter and done strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        count <= ps2_display_pkg::DIV_COUNT_INIT;
      end else if (running) begin
        count <= count - 1'b1;
        done  <= last_step;   // Remainder is final in the next cycle
      end
    end
  end

  // --------------------
  // Datapath
  always_ff @(posedge clk) begin
    if (start) begin
      acc <= {{ps2_display_pkg::BYTE_W{1'b0}}, dividend};
    end else if (running) begin
      if (last_step) begin
        acc <= {rem_fixed, acc_shifted[ps2_display_pkg::BYTE_W-1:0]};
      end else begin
        acc <= {rem_step, acc_shifted[ps2_display_pkg::BYTE_W-1:0]};
      end
      // Quotient bit is one when the new remainder is not negative
      quotient <= {quotient[ps2_display_pkg::BYTE_W-2:0], ~rem_step[ps2_display_pkg::BYTE_W-1]};
    end
  end

endmodule

// File: hw/decimal_converter.sv
`timescale 1ns/1ps

module decimal_converter (
  input  logic                        clk,
  input  logic                        reset,
  input  ps2_display_pkg::scan_byte_t scan_code,
  input  logic                        scan_valid,
  output logic [ps2_display_pkg::DEC_DIGITS-1:0][ps2_display_pkg::NIBBLE_W-1:0] dec_digits,
  output logic                        dec_update   // Digits are new this cycle
);

  logic [ps2_display_pkg::CV_STATE_W-1:0]  state;
  logic [ps2_display_pkg::DIGIT_IDX_W-1:0] digit_idx;   // Digit being produced, ones first
  logic [ps2_display_pkg::BYTE_W-1:0]      dividend_q;  // Quotient fed back
  logic                                    start_q;     // Start of the next division
  logic [ps2_display_pkg::DEC_DIGITS-2:0][ps2_display_pkg::NIBBLE_W-1:0] digit_sr;
  logic                                    accept;      // New byte taken this cycle
  logic                                    last_digit;

  // --------------------
  // Divider port
  logic                               div_start;
  logic [ps2_display_pkg::BYTE_W-1:0] div_dividend;
  logic [ps2_display_pkg::BYTE_W-1:0] div_quotient;
  logic [ps2_display_pkg::BYTE_W-1:0] div_remainder;
  logic                               div_done;

  assign accept     = (state == ps2_display_pkg::CV_IDLE) && scan_valid;
  assign last_digit = (digit_idx == ps2_display_pkg::LAST_DIGIT);
  // First division starts straight from the strobe
  assign div_start    = accept | start_q;
  assign div_dividend = accept ? scan_code.raw : dividend_q;

  base_divider u_divider (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .dividend  (div_dividend),
    .quotient  (div_quotient),
    .remainder (div_remainder),
    .done      (div_done)
  );

  // Conversion FSM, bytes arriving while busy are dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ps2_display_pkg::CV_IDLE;
      digit_idx  <= '0;
      start_q    <= 1'b0;
      dec_update <= 1'b0;
    end else begin
      start_q    <= 1'b0;
      dec_update <= 1'b0;
      case (state)
        ps2_display_pkg::CV_IDLE: begin
          if (scan_valid) begin
            state     <= ps2_display_pkg::CV_DIVIDE;
            digit_idx <= '0;
          end
        end
        default: begin
          if (div_done) begin
            if (last_digit) begin
              state      <= ps2_display_pkg::CV_IDLE;
              dec_update <= 1'b1;        // Hundreds just arrived
            end else begin
              digit_idx <= digit_idx + 1'b1;
              start_q   <= 1'b1;         // Divide the quotient again
            end
          end
        end
      endcase
    end
  end

  // Digit store, publish all digits at once
  always_ff @(posedge clk) begin
    if (state == ps2_display_pkg::CV_DIVIDE && div_done) begin
      if (last_digit) begin
        dec_digits <= {div_remainder[ps2_display_pkg::NIBBLE_W-1:0], digit_sr};
      end else begin
        digit_sr   <= {div_remainder[ps2_display_pkg::NIBBLE_W-1:0],
                       digit_sr[ps2_display_pkg::DEC_DIGITS-2:1]};
        dividend_q <= div_quotient;
      end
    end
  end

endmodule

// File: hw/segment_display.sv
`timescale 1ns/1ps

module segment_display (
  input  logic                        clk,
  input  logic                        reset,
  input  ps2_display_pkg::scan_byte_t scan_code,
  input  logic                        scan_valid,
  input  logic [ps2_display_pkg::DEC_DIGITS-1:0][ps2_display_pkg::NIBBLE_W-1:0] dec_digits,
  input  logic                        dec_update,
  output logic [ps2_display_pkg::SEG_W-1:0] hex_hi_seg,        // Upper nibble
  output logic [ps2_display_pkg::SEG_W-1:0] hex_lo_seg,        // Lower nibble
  output logic [ps2_display_pkg::SEG_W-1:0] dec_seg_hundreds,
  output logic [ps2_display_pkg::SEG_W-1:0] dec_seg_tens,
  output logic [ps2_display_pkg::SEG_W-1:0] dec_seg_ones
);

  // --------------------
  // Hex digits
  always_ff @(posedge clk) begin
    if (reset) begin
      hex_hi_seg <= ps2_display_pkg::seg_encode('0);  // Show 0 after reset
      hex_lo_seg <= ps2_display_pkg::seg_encode('0);
    end else if (scan_valid) begin
      hex_hi_seg <= ps2_display_pkg::seg_encode(scan_code.nibble.hi);
      hex_lo_seg <= ps2_display_pkg::seg_encode(scan_code.nibble.lo);
    end
  end

  // --------------------
  // Decimal digits
  always_ff @(posedge clk) begin
    if (reset) begin
      dec_seg_hundreds <= ps2_display_pkg::seg_encode('0);
      dec_seg_tens     <= ps2_display_pkg::seg_encode('0);
      dec_seg_ones     <= ps2_display_pkg::seg_encode('0);
    end else if (dec_update) begin  // Latch a finished conversion
      dec_seg_hundreds <= ps2_display_pkg::seg_encode(dec_digits[2]);
      dec_seg_tens     <= ps2_display_pkg::seg_encode(dec_digits[1]);
      dec_seg_ones     <= ps2_display_pkg::seg_encode(dec_digits[0]);
    end
  end

endmodule

// File: hw/ps2_code_display.sv
`timescale 1ns/1ps

module ps2_code_display (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              ps2_clk,
  input  logic                              ps2_data,
  output ps2_display_pkg::scan_byte_t       scan_code,
  output logic                              scan_valid,
  output logic                              frame_error,
  output logic                              dec_update,
  output logic [ps2_display_pkg::SEG_W-1:0] hex_hi_seg,
  output logic [ps2_display_pkg::SEG_W-1:0] hex_lo_seg,
  output logic [ps2_display_pkg::SEG_W-1:0] dec_seg_hundreds,
  output logic [ps2_display_pkg::SEG_W-1:0] dec_seg_tens,
  output logic [ps2_display_pkg::SEG_W-1:0] dec_seg_ones
);

  // Ones in entry 0
  logic [ps2_display_pkg::DEC_DIGITS-1:0][ps2_display_pkg::NIBBLE_W-1:0] dec_digits;

  ps2_receiver u_receiver (
    .clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .scan_code(scan_code), .scan_valid(scan_valid), .frame_error(frame_error)
  );

  decimal_converter u_converter (
    .clk(clk), .reset(reset), .scan_code(scan_code), .scan_valid(scan_valid),
    .dec_digits(dec_digits), .dec_update(dec_update)
  );

  segment_display u_display (
    .clk(clk), .reset(reset),
    .scan_code(scan_code), .scan_valid(scan_valid),
    .dec_digits(dec_digits), .dec_update(dec_update),
    .hex_hi_seg(hex_hi_seg), .hex_lo_seg(hex_lo_seg),
    .dec_seg_hundreds(dec_seg_hundreds), .dec_seg_tens(dec_seg_tens),
    .dec_seg_ones(dec_seg_ones)
  );

endmodule

// File: testbench/ps2_code_display_assert.sv
`timescale 1ns/1ps

module ps2_code_display_assert (
  input logic clk,
  input logic reset,
  input logic scan_valid,
  input logic frame_error,
  input logic dec_update
);

  logic conv_busy;          // Conversion in flight
  int   assert_errors = 0;  // Failed assertions so far

  always_ff @(posedge clk) begin
    if (reset) begin
      conv_busy <= 1'b0;
    end else if (dec_update) begin
      conv_busy <= 1'b0;
    end else if (scan_valid) begin
      conv_busy <= 1'b1;
    end
  end

  // --------------------
  // Strobes last one cycle
  a_scan_valid_pulse: assert property (@(posedge clk) disable iff (reset)
    scan_valid |=> !scan_valid)
    else begin
      $error("scan_valid high for two cycles");
      assert_errors++;
    end
  a_frame_error_pulse: assert property (@(posedge clk) disable iff (reset)
    frame_error |=> !frame_error)
    else begin
      $error("frame_error high for two cycles");
      assert_errors++;
    end
  a_dec_update_pulse: assert property (@(posedge clk) disable iff (reset)
    dec_update |=> !dec_update)
    else begin
      $error("dec_update high for two cycles");
      assert_errors++;
    end

  // Good and bad frame are exclusive
  a_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(scan_valid && frame_error))
    else begin
      $error("scan_valid and frame_error together");
      assert_errors++;
    end

  // Conversion finishes in time when the converter was idle
  a_dec_latency: assert property (@(posedge clk) disable iff (reset)
    (scan_valid && !conv_busy) |-> ##[1:30] dec_update)
    else begin
      $error("dec_update missing after scan_valid");
      assert_errors++;
    end

endmodule

bind ps2_code_display ps2_code_display_assert u_assert (
  .clk         (clk),
  .reset       (reset),
  .scan_valid  (scan_valid),
  .frame_error (frame_error),
  .dec_update  (dec_update)
);

// File: testbench/ps2_checker.sv
`timescale 1ns/1ps

// Reference model and comparator at the DUT ports
module ps2_checker (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [ps2_display_pkg::BYTE_W-1:0] scan_code,
  input  logic                              scan_valid,
  input  logic                              frame_error,
  input  logic                              dec_update,
  input  logic [ps2_display_pkg::SEG_W-1:0] hex_hi_seg,
  input  logic [ps2_display_pkg::SEG_W-1:0] hex_lo_seg,
  input  logic [ps2_display_pkg::SEG_W-1:0] dec_seg_hundreds,
  input  logic [ps2_display_pkg::SEG_W-1:0] dec_seg_tens,
  input  logic [ps2_display_pkg::SEG_W-1:0] dec_seg_ones,
  input  logic                              exp_push,    // Driver announces a frame
  input  logic [ps2_display_pkg::BYTE_W-1:0] exp_byte,
  input  logic                              exp_fault,
  input  logic                              test_done,
  input  int                                test_id,
  output logic                              busy,        // Frames or conversion outstanding
  output int                                tests_passed,
  output int                                tests_failed,
  output int                                error_count
);

  localparam int DEC_LATENCY = ps2_display_pkg::DEC_DIGITS * (ps2_display_pkg::DIV_STEPS + 2);

  logic [8:0] expected_q[$];  // {fault, byte}
  logic [8:0] entry;
  logic [7:0] model_code;
  logic [7:0] conv_byte;      // Byte under conversion
  logic [6:0] model_hex_hi;
  logic [6:0] model_hex_lo;
  logic [6:0] model_hundreds;
  logic [6:0] model_tens;
  logic [6:0] model_ones;
  logic       good_seen;
  logic       dec_pending;
  int         dec_wait;       // Cycles since the conversion began
  int         group_errors[3]; // Strobes and scan_code, hex, decimal

  // Active low, bit 0 top bar, bit 6 middle bar
  function automatic logic [6:0] seg_pattern(input int digit);
    case (digit)
      0: return 7'b1000000;
      1: return 7'b1111001;
      2: return 7'b0100100;
      3: return 7'b0110000;
      4: return 7'b0011001;
      5: return 7'b0010010;
      6: return 7'b0000010;
      7: return 7'b1111000;
      8: return 7'b0000000;
      9: return 7'b0010000;
      10: return 7'b0001000;
      11: return 7'b0000011;
      12: return 7'b1000110;
      13: return 7'b0100001;
      14: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state";
      2: return "good frames and scan_code";
      3: return "hex segments";
      4: return "decimal segments";
      default: return "faulty frames";
    endcase
  endfunction

  task automatic check_value(input int group, input string name,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail at %0d ns: %s expected %0h, actual %0h", $time, name, expected, actual);
      group_errors[group]++;
      error_count++;
    end
  endtask

  task automatic report_error(input int group, input string what);
    $display("Error at %0d ns: %s", $time, what);
    group_errors[group]++;
    error_count++;
  endtask

  // Each test owns some error groups; the fault test takes all that are left
  task automatic report_test(input int id);
    logic [2:0] groups;
    int         errors;
    groups = (id == 2) ? 3'b001 : (id == 3) ? 3'b010 : (id == 4) ? 3'b100 : 3'b111;
    errors = 0;
    for (int g = 0; g < 3; g++) begin
      if (groups[g]) begin
        errors += group_errors[g];
        group_errors[g] = 0;
      end
    end
    if (errors == 0) begin
      tests_passed++;
      $display("Test %0d, %s: passed", id, test_name(id));
    end else begin
      tests_failed++;
      $display("Test %0d, %s: %0d errors", id, test_name(id), errors);
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      expected_q.delete();
      model_code     = '0;
      model_hex_hi   = seg_pattern(0);
      model_hex_lo   = seg_pattern(0);
      model_hundreds = seg_pattern(0);
      model_tens     = seg_pattern(0);
      model_ones     = seg_pattern(0);
      dec_pending    = 1'b0;
      dec_wait       = 0;
      busy           = 1'b0;
      tests_passed   = 0;
      tests_failed   = 0;
      error_count    = 0;
      foreach (group_errors[g]) group_errors[g] = 0;
    end else begin
      good_seen = 1'b0;
      if (exp_push) expected_q.push_back({exp_fault, exp_byte});
      if (dec_pending) dec_wait++;
      // --------------------
      // Frame strobes
      if (scan_valid || frame_error) begin
        if (expected_q.size() == 0) begin
          report_error(0, "strobe with no frame sent");
        end else begin
          entry = expected_q.pop_front();
          if (scan_valid && entry[8]) report_error(0, "scan_valid on a frame sent with a fault");
          if (frame_error && !entry[8]) report_error(0, "frame_error on a well-formed frame");
          if (scan_valid && !entry[8]) begin
            model_code = entry[7:0];  // scan_code is new with the strobe
            good_seen  = 1'b1;
          end
        end
      end
      check_value(0, "scan_code", model_code, scan_code);
      check_value(1, "hex_hi_seg", model_hex_hi, hex_hi_seg);
      check_value(1, "hex_lo_seg", model_hex_lo, hex_lo_seg);
      check_value(2, "dec_seg_hundreds", model_hundreds, dec_seg_hundreds);
      check_value(2, "dec_seg_tens", model_tens, dec_seg_tens);
      check_value(2, "dec_seg_ones", model_ones, dec_seg_ones);
      // --------------------
      // Display changes one cycle after its strobe
      if (good_seen) begin
        model_hex_hi = seg_pattern(model_code[7:4]);
        model_hex_lo = seg_pattern(model_code[3:0]);
        if (!dec_pending) begin  // Busy converter drops the byte
          conv_byte   = model_code;
          dec_pending = 1'b1;
          dec_wait    = 0;
        end
      end
      if (dec_update) begin
        if (!dec_pending) begin
          report_error(2, "dec_update with no conversion running");
        end else begin
          check_value(2, "dec_update latency", DEC_LATENCY, dec_wait);
          model_hundreds = seg_pattern(conv_byte / 100);
          model_tens     = seg_pattern((conv_byte / 10) % 10);
          model_ones     = seg_pattern(conv_byte % 10);
          dec_pending    = 1'b0;
        end
      end
      if (test_done) report_test(test_id);
      busy = (expected_q.size() != 0) || dec_pending;
    end
  end

endmodule

// File: testbench/tb_ps2_code_display.sv
`timescale 1ns/1ps

module tb_ps2_code_display;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int HALF_CYCLES  = 8;    // clk cycles per PS/2 half period
  localparam int GAP_CYCLES   = 20;   // Idle between frames
  localparam int FRAME_BITS   = 11;   // Start, 8 data, parity, stop
  localparam int FRAMES       = 20;   // Per frame test
  // Frame plus gap and strobe slack, two frame tests, twice over
  localparam int FRAME_CYCLES   = FRAME_BITS * 2 * HALF_CYCLES + GAP_CYCLES + 4;
  localparam int TIMEOUT_CYCLES = 2 * 2 * FRAMES * FRAME_CYCLES;
  localparam logic [15:0] LFSR_SEED = 16'd8500;
  localparam logic [15:0] LFSR_TAPS = 16'hb400;  // x^16 + x^14 + x^13 + x^11 + 1

  logic clk;
  logic reset;
  logic ps2_clk;
  logic ps2_data;
  ps2_display_pkg::scan_byte_t scan_code;
  logic scan_valid;
  logic frame_error;
  logic dec_update;
  logic [ps2_display_pkg::SEG_W-1:0] hex_hi_seg;
  logic [ps2_display_pkg::SEG_W-1:0] hex_lo_seg;
  logic [ps2_display_pkg::SEG_W-1:0] dec_seg_hundreds;
  logic [ps2_display_pkg::SEG_W-1:0] dec_seg_tens;
  logic [ps2_display_pkg::SEG_W-1:0] dec_seg_ones;

  // --------------------
  // Checker side
  logic       exp_push;
  logic [7:0] exp_byte;
  logic       exp_fault;
  logic       test_done;
  int         test_id;
  logic       busy;
  int         tests_passed;
  int         tests_failed;
  int         error_count;

  logic [15:0] lfsr_state;
  int          cycle_count;
  logic [7:0]  rand_byte;
  logic [7:0]  fault_pick;   // Bit 0 picks stop fault over parity fault

  ps2_code_display dut (
    .clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .scan_code(scan_code), .scan_valid(scan_valid), .frame_error(frame_error),
    .dec_update(dec_update), .hex_hi_seg(hex_hi_seg), .hex_lo_seg(hex_lo_seg),
    .dec_seg_hundreds(dec_seg_hundreds), .dec_seg_tens(dec_seg_tens),
    .dec_seg_ones(dec_seg_ones)
  );

  ps2_checker u_checker (
    .clk(clk), .reset(reset), .scan_code(scan_code.raw), .scan_valid(scan_valid),
    .frame_error(frame_error), .dec_update(dec_update),
    .hex_hi_seg(hex_hi_seg), .hex_lo_seg(hex_lo_seg),
    .dec_seg_hundreds(dec_seg_hundreds), .dec_seg_tens(dec_seg_tens),
    .dec_seg_ones(dec_seg_ones), .exp_push(exp_push), .exp_byte(exp_byte),
    .exp_fault(exp_fault), .test_done(test_done), .test_id(test_id), .busy(busy),
    .tests_passed(tests_passed), .tests_failed(tests_failed), .error_count(error_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int count, output logic [7:0] value);
    value = '0;
    repeat (count) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[6:0], lfsr_state[0]};
    end
  endtask

  task automatic drive_bit(input logic value);
    ps2_data = value;            // Data moves while ps2_clk is high
    repeat (HALF_CYCLES) @(negedge clk);
    ps2_clk = 1'b0;              // Receiver samples on this edge
    repeat (HALF_CYCLES) @(negedge clk);
    ps2_clk = 1'b1;
  endtask

  task automatic send_frame(input logic [7:0] value, input logic bad_parity,
                            input logic bad_stop);
    logic parity_bit;
    parity_bit = ~(^value) ^ bad_parity;  // Odd parity over data and parity
    exp_push   = 1'b1;
    exp_byte   = value;
    exp_fault  = bad_parity | bad_stop;
    @(negedge clk);
    exp_push = 1'b0;
    drive_bit(1'b0);                      // Start
    for (int i = 0; i < 8; i++) begin
      drive_bit(value[i]);                // LSB first
    end
    drive_bit(parity_bit);
    drive_bit(~bad_stop);
    ps2_data = 1'b1;
    repeat (GAP_CYCLES) @(negedge clk);
  endtask

  // Waits for outstanding strobes and conversions, then closes the test
  task automatic finish_test(input int id);
    while (busy) @(negedge clk);
    test_id   = id;
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    ps2_clk     = 1'b1;   // Idle bus
    ps2_data    = 1'b1;
    exp_push    = 1'b0;
    exp_byte    = '0;
    exp_fault   = 1'b0;
    test_done   = 1'b0;
    test_id     = 0;
    lfsr_state  = LFSR_SEED;
    cycle_count = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);  // Quiet bus after reset
    finish_test(1);
    // --------------------
    // Well-formed frames
    repeat (FRAMES) begin
      draw_bits(8, rand_byte);
      send_frame(rand_byte, 1'b0, 1'b0);
    end
    finish_test(2);
    finish_test(3);
    finish_test(4);
    // --------------------
    // Frames with one fault each
    repeat (FRAMES) begin
      draw_bits(8, rand_byte);
      draw_bits(1, fault_pick);
      send_frame(rand_byte, ~fault_pick[0], fault_pick[0]);
    end
    finish_test(5);
    @(negedge clk);
    $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d, assertion failures: %0d",
             tests_passed, tests_failed, error_count, dut.u_assert.assert_errors);
    if (tests_failed == 0 && error_count == 0 && dut.u_assert.assert_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: ps2_code_display.f
hw/ps2_display_pkg.sv
hw/ps2_receiver.sv
hw/base_divider.sv
hw/decimal_converter.sv
hw/segment_display.sv
hw/ps2_code_display.sv
testbench/ps2_code_display_assert.sv
testbench/ps2_checker.sv
testbench/tb_ps2_code_display.sv

// File: Bender.yml
package:
  name: ps2_code_display

sources:
  - hw/ps2_display_pkg.sv
  - hw/ps2_receiver.sv
  - hw/base_divider.sv
  - hw/decimal_converter.sv
  - hw/segment_display.sv
  - hw/ps2_code_display.sv
  - target: test
    files:
      - testbench/ps2_code_display_assert.sv
      - testbench/ps2_checker.sv
      - testbench/tb_ps2_code_display.sv
